// File: verilog.f
bp_me_msg_pkg.sv
bp_me_addr_pkg.sv
bp_me_dev_if.sv
bp_me_fwd_router.sv
bp_me_rev_arb.sv
bp_me_cfg_slice.sv
bp_me_clint_slice.sv
bp_me_mem_slice.sv
bp_me_loopback.sv
bp_me_device_complex.sv
tb_bp_me_device_complex.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the device complex testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
  -f verilog.f --top-module tb_bp_me_device_complex -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF -- '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: tb_bp_me_device_complex.sv
/*
 * Device complex testbench
 * Random command stream checked against a reference model of all slices
 */

`timescale 1ns/1ns
`default_nettype none

module tb_bp_me_device_complex;
  import bp_me_msg_pkg::*;

  localparam int mem_words_lp      = 64;
  localparam int half_period_lp    = 4;
  localparam int cycles_per_cmd_lp = 20;
  localparam int num_random_lp     = 170;
  localparam int idle_cycles_lp    = 8;

  logic          clk_i;
  logic          reset_i;
  bp_me_opcode_e mem_fwd_opcode_i;
  logic [31:0]   mem_fwd_addr_i;
  logic [7:0]    mem_fwd_tag_i;
  logic [63:0]   mem_fwd_data_i;
  logic          mem_fwd_v_i;
  logic          mem_fwd_ready_and_o;
  bp_me_opcode_e mem_rev_opcode_o;
  logic [31:0]   mem_rev_addr_o;
  logic [7:0]    mem_rev_tag_o;
  logic [63:0]   mem_rev_data_o;
  logic          mem_rev_v_o;
  logic          mem_rev_ready_and_i;
  logic [7:0]    did_i;
  logic [7:0]    host_did_i;
  logic          freeze_o;
  logic [7:0]    core_id_o;
  logic          timer_irq_o;
  logic          software_irq_o;

  integer seed = 32'h7173_3ed5;

  bp_me_opcode_e cmd_op_q   [$];
  logic [31:0]   cmd_addr_q [$];
  logic [63:0]   cmd_data_q [$];
  int            n_cmds;
  bit            cmds_ready;

  // Reference model state
  logic [63:0] mem_m [mem_words_lp];
  logic        freeze_m;
  logic [7:0]  core_id_m;
  logic        msip_m;
  logic [63:0] mtimecmp_m;

  // Expected response, indexed by tag
  bp_me_opcode_e exp_op   [256];
  logic [31:0]   exp_addr [256];
  logic [63:0]   exp_data [256];
  bit            exp_data_chk [256];
  bit            pending  [256];
  int            pending_cnt;

  bp_me_device_complex #(.mem_words_p(mem_words_lp)) i_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #half_period_lp clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0t ns: %s is %h, expected %h",
                         $time, name, actual, expected));
    end
  endtask

  function automatic logic [31:0] local_addr(input logic [3:0] dev, input logic [19:0] off,
                                             input logic [6:0] pad);
    return {1'b0, pad, dev, off};
  endfunction

  task automatic push_cmd(input bp_me_opcode_e op, input logic [31:0] addr,
                          input logic [63:0] data);
    cmd_op_q.push_back(op);
    cmd_addr_q.push_back(addr);
    cmd_data_q.push_back(data);
  endtask

  task automatic add_random_cmd();
    int            sel;
    int            k;
    bp_me_opcode_e op;
    logic [31:0]   addr;
    logic [63:0]   data;
    logic [3:0]    dev;
    logic [6:0]    pad;
    sel  = {$random(seed)} % 8;
    op   = (($random(seed) & 1) != 0) ? e_wr : e_rd;
    data = {32'($random(seed)), 32'($random(seed))};
    pad  = 7'($random(seed));
    case (sel)
      0, 1, 2: addr = 32'h8000_0000 | (32'($random(seed)) & 32'h7FFF_FFF8);
      3:       addr = local_addr(4'd3, 20'($random(seed)) & 20'hFFFF8, pad);
      4:       addr = local_addr(4'd1, 20'(({$random(seed)} % 5) * 8), pad);
      5: begin
        k = {$random(seed)} % 3;
        if (k == 0) begin
          addr = local_addr(4'd2, 20'h0000, pad);
        end else if (k == 1) begin
          addr = local_addr(4'd2, 20'h4000, pad);
          data = (($random(seed) & 1) != 0) ? 64'd0 : '1;
        end else begin
          // mtime is only ever read
          addr = local_addr(4'd2, 20'hBFF8, pad);
          op   = e_rd;
        end
      end
      default: begin
        dev  = 4'({$random(seed)} % 13);
        dev  = (dev == 4'd0) ? 4'd0 : dev + 4'd3;
        addr = local_addr(dev, 20'($random(seed)), pad);
      end
    endcase
    push_cmd(op, addr, data);
  endtask

  // Applies one accepted command to the model and records its response
  task automatic accept_cmd(input int i);
    bp_me_opcode_e op;
    logic [31:0]   a;
    logic [63:0]   d;
    logic [63:0]   rd;
    logic [7:0]    tag;
    int            widx;
    bit            chk;
    op  = cmd_op_q[i];
    a   = cmd_addr_q[i];
    d   = cmd_data_q[i];
    tag = 8'(i);
    rd  = '0;
    chk = 1'b1;
    if (a >= 32'h8000_0000 || a[23:20] == 4'd3) begin
      widx = int'((a >> 3) % mem_words_lp);
      if (op == e_wr) mem_m[widx] = d;
      else rd = mem_m[widx];
    end else if (a[23:20] == 4'd1) begin
      case (a[19:0])
        20'h00: if (op == e_wr) freeze_m = d[0]; else rd = {63'd0, freeze_m};
        20'h08: if (op == e_wr) core_id_m = d[7:0]; else rd = {56'd0, core_id_m};
        20'h10: rd = {56'd0, did_i};
        20'h18: rd = {56'd0, host_did_i};
        default: rd = '0;
      endcase
    end else if (a[23:20] == 4'd2) begin
      case (a[19:0])
        20'h0000: if (op == e_wr) msip_m = d[0]; else rd = {63'd0, msip_m};
        20'h4000: if (op == e_wr) mtimecmp_m = d; else rd = mtimecmp_m;
        default:  chk = 1'b0;
      endcase
    end
    exp_op[tag]       = op;
    exp_addr[tag]     = a;
    exp_data[tag]     = (op == e_wr) ? 64'd0 : rd;
    exp_data_chk[tag] = chk || (op == e_wr);
    pending[tag]      = 1'b1;
    pending_cnt++;
  endtask

  task automatic check_sideband();
    check_value("freeze_o", 64'(freeze_o), 64'(freeze_m));
    check_value("core_id_o", 64'(core_id_o), 64'(core_id_m));
    check_value("software_irq_o", 64'(software_irq_o), 64'(msip_m));
    check_value("timer_irq_o", 64'(timer_irq_o), 64'(mtimecmp_m == 64'd0));
  endtask

  task automatic check_response();
    logic [7:0] tag;
    tag = mem_rev_tag_o;
    if (!pending[tag]) begin
      fail_run($sformatf("Response with tag %0d at %0t ns has no outstanding command",
                         tag, $time));
    end else begin
      check_value("mem_rev_opcode_o", 64'(mem_rev_opcode_o), 64'(exp_op[tag]));
      check_value("mem_rev_addr_o", 64'(mem_rev_addr_o), 64'(exp_addr[tag]));
      if (exp_data_chk[tag]) begin
        check_value("mem_rev_data_o", mem_rev_data_o, exp_data[tag]);
      end
      pending[tag] = 1'b0;
      pending_cnt--;
    end
  endtask

  initial begin : watchdog
    wait (cmds_ready);
    repeat ((n_cmds + 5) * cycles_per_cmd_lp) @(posedge clk_i);
    fail_run($sformatf("Timeout: %0d of %0d responses still missing", pending_cnt, n_cmds));
  end

  initial begin : stimulus
    int idx;
    bit fwd_fire;
    bit rev_fire;
    idx                 = 0;
    reset_i             = 1'b1;
    mem_fwd_opcode_i    = e_rd;
    mem_fwd_addr_i      = '0;
    mem_fwd_tag_i       = '0;
    mem_fwd_data_i      = '0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    did_i               = 8'($random(seed));
    host_did_i          = 8'($random(seed));
    freeze_m            = 1'b1;
    core_id_m           = '0;
    msip_m              = 1'b0;
    mtimecmp_m          = '1;
    pending_cnt         = 0;
    foreach (pending[t]) pending[t] = 1'b0;

    // Fill the whole RAM first so every read has a known word
    for (int w = 0; w < mem_words_lp; w++) begin
      push_cmd(e_wr, 32'h8000_0000 | 32'(w << 3), {32'($random(seed)), 32'($random(seed))});
    end
    push_cmd(e_wr, local_addr(4'd1, 20'h00, 7'h00), 64'd0);
    push_cmd(e_rd, local_addr(4'd1, 20'h00, 7'h00), 64'd0);
    push_cmd(e_wr, local_addr(4'd1, 20'h08, 7'h00), 64'h5A);
    push_cmd(e_rd, local_addr(4'd1, 20'h08, 7'h00), 64'd0);
    push_cmd(e_wr, local_addr(4'd1, 20'h10, 7'h00), 64'hFF);
    push_cmd(e_rd, local_addr(4'd1, 20'h10, 7'h00), 64'd0);
    push_cmd(e_rd, local_addr(4'd1, 20'h18, 7'h00), 64'd0);
    push_cmd(e_wr, local_addr(4'd2, 20'h0000, 7'h00), 64'd1);
    push_cmd(e_rd, local_addr(4'd2, 20'h0000, 7'h00), 64'd0);
    push_cmd(e_wr, local_addr(4'd2, 20'h4000, 7'h00), 64'd0);
    push_cmd(e_rd, local_addr(4'd2, 20'h4000, 7'h00), 64'd0);
    push_cmd(e_wr, local_addr(4'd2, 20'h4000, 7'h00), '1);
    push_cmd(e_rd, local_addr(4'd2, 20'h4000, 7'h00), 64'd0);
    push_cmd(e_wr, local_addr(4'd2, 20'h0000, 7'h00), 64'd0);
    for (int r = 0; r < num_random_lp; r++) begin
      add_random_cmd();
    end
    n_cmds     = cmd_op_q.size();
    cmds_ready = 1'b1;

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    while (idx < n_cmds || pending_cnt != 0) begin
      @(negedge clk_i);
      check_sideband();
      fwd_fire = mem_fwd_v_i && mem_fwd_ready_and_o;
      rev_fire = mem_rev_v_o && mem_rev_ready_and_i;
      if (rev_fire) check_response();
      if (fwd_fire) begin
        accept_cmd(idx);
        idx++;
      end
      @(posedge clk_i);
      mem_rev_ready_and_i <= (($random(seed) & 3) != 0);
      // A raised command holds until it transfers
      if (!mem_fwd_v_i || fwd_fire) begin
        if (idx < n_cmds && (($random(seed) & 7) != 0)) begin
          mem_fwd_opcode_i <= cmd_op_q[idx];
          mem_fwd_addr_i   <= cmd_addr_q[idx];
          mem_fwd_tag_i    <= 8'(idx);
          mem_fwd_data_i   <= cmd_data_q[idx];
          mem_fwd_v_i      <= 1'b1;
        end else begin
          mem_fwd_v_i <= 1'b0;
        end
      end
    end

    // Every tag is back, so the reverse stream must stay idle
    mem_rev_ready_and_i <= 1'b1;
    mem_fwd_v_i         <= 1'b0;
    repeat (idle_cycles_lp) begin
      @(negedge clk_i);
      check_sideband();
      check_value("mem_rev_v_o", 64'(mem_rev_v_o), 64'd0);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: bp_me_device_complex.sv
/*
 * Device complex
 * Routes memory-forward commands to the tile's uncached devices
 * and merges their responses onto one reverse stream
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_device_complex
  #(parameter int mem_words_p = 256)
  (input wire                                           clk_i
   , input wire                                         reset_i

   , input wire bp_me_msg_pkg::bp_me_opcode_e           mem_fwd_opcode_i
   , input wire [bp_me_msg_pkg::paddr_width_gp-1:0]     mem_fwd_addr_i
   , input wire [bp_me_msg_pkg::tag_width_gp-1:0]       mem_fwd_tag_i
   , input wire [bp_me_msg_pkg::data_width_gp-1:0]      mem_fwd_data_i
   , input wire                                         mem_fwd_v_i
   , output logic                                       mem_fwd_ready_and_o

   , output bp_me_msg_pkg::bp_me_opcode_e               mem_rev_opcode_o
   , output logic [bp_me_msg_pkg::paddr_width_gp-1:0]   mem_rev_addr_o
   , output logic [bp_me_msg_pkg::tag_width_gp-1:0]     mem_rev_tag_o
   , output logic [bp_me_msg_pkg::data_width_gp-1:0]    mem_rev_data_o
   , output logic                                       mem_rev_v_o
   , input wire                                         mem_rev_ready_and_i

   , input wire [7:0]                                   did_i
   , input wire [7:0]                                   host_did_i
   , output logic                                       freeze_o
   , output logic [7:0]                                 core_id_o
   , output logic                                       timer_irq_o
   , output logic                                       software_irq_o
   );

  import bp_me_addr_pkg::*;

  // One stream pair per slice, indexed by bp_dev_e
  bp_me_dev_if dev_if [4] ();

  bp_me_fwd_router
   router
    (.mem_fwd_opcode_i(mem_fwd_opcode_i)
     ,.mem_fwd_addr_i(mem_fwd_addr_i)
     ,.mem_fwd_tag_i(mem_fwd_tag_i)
     ,.mem_fwd_data_i(mem_fwd_data_i)
     ,.mem_fwd_v_i(mem_fwd_v_i)
     ,.mem_fwd_ready_and_o(mem_fwd_ready_and_o)
     ,.dev_o(dev_if)
     );

  bp_me_mem_slice
   #(.mem_words_p(mem_words_p))
   mem
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dev_io(dev_if[e_dev_mem])
     );

  bp_me_cfg_slice
   cfg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dev_io(dev_if[e_dev_cfg])
     ,.did_i(did_i)
     ,.host_did_i(host_did_i)
     ,.freeze_o(freeze_o)
     ,.core_id_o(core_id_o)
     );

  bp_me_clint_slice
   clint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dev_io(dev_if[e_dev_clint])
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  bp_me_loopback
   loopback
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dev_io(dev_if[e_dev_loop])
     );

  bp_me_rev_arb
   rev_arb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dev_i(dev_if)
     ,.mem_rev_opcode_o(mem_rev_opcode_o)
     ,.mem_rev_addr_o(mem_rev_addr_o)
     ,.mem_rev_tag_o(mem_rev_tag_o)
     ,.mem_rev_data_o(mem_rev_data_o)
     ,.mem_rev_v_o(mem_rev_v_o)
     ,.mem_rev_ready_and_i(mem_rev_ready_and_i)
     );

endmodule

`default_nettype wire

// File: bp_me_loopback.sv
/*
 * Loopback slice
 * Answers unmapped local commands with zero data
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_loopback
  (input wire         clk_i
   , input wire       reset_i

   , bp_me_dev_if.dev dev_io
   );

  logic fwd_yumi;

  assign dev_io.fwd_ready_and = ~dev_io.rev_v | dev_io.rev_ready_and;
  assign fwd_yumi = dev_io.fwd_v & dev_io.fwd_ready_and;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dev_io.rev_v <= 1'b0;
    end else if (fwd_yumi) begin
      dev_io.rev_v <= 1'b1;
    end else if (dev_io.rev_ready_and) begin
      dev_io.rev_v <= 1'b0;
    end
  end

  // Header echoed as is
  always_ff @(posedge clk_i) begin
    if (fwd_yumi) begin
      dev_io.rev_opcode <= dev_io.fwd_opcode;
      dev_io.rev_addr   <= dev_io.fwd_addr;
      dev_io.rev_tag    <= dev_io.fwd_tag;
      dev_io.rev_data   <= '0;
    end
  end

endmodule

`default_nettype wire

// File: bp_me_mem_slice.sv
/*
 * Memory slice
 * Single-port RAM of 64-bit words answering reads and writes
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_mem_slice
  #(parameter int mem_words_p = 256)
  (input wire         clk_i
   , input wire       reset_i

   , bp_me_dev_if.dev dev_io
   );

  import bp_me_msg_pkg::*;

  localparam int idx_width_lp = $clog2(mem_words_p);

  logic [data_width_gp-1:0] mem_r [mem_words_p];
  logic [idx_width_lp-1:0]  word_idx;
  logic                     fwd_yumi;
  logic                     wr_v;

  // Drop the byte offset, wrap on the depth
  assign word_idx = idx_width_lp'((dev_io.fwd_addr >> 3) % mem_words_p);

  assign dev_io.fwd_ready_and = ~dev_io.rev_v | dev_io.rev_ready_and;
  assign fwd_yumi = dev_io.fwd_v & dev_io.fwd_ready_and;
  assign wr_v     = fwd_yumi & (dev_io.fwd_opcode == e_wr);

  always_ff @(posedge clk_i) begin
    if (wr_v) begin
      mem_r[word_idx] <= dev_io.fwd_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dev_io.rev_v <= 1'b0;
    end else if (fwd_yumi) begin
      dev_io.rev_v <= 1'b1;
    end else if (dev_io.rev_ready_and) begin
      dev_io.rev_v <= 1'b0;
    end
  end

  // Write acks return zero data
  always_ff @(posedge clk_i) begin
    if (fwd_yumi) begin
      dev_io.rev_opcode <= dev_io.fwd_opcode;
      dev_io.rev_addr   <= dev_io.fwd_addr;
      dev_io.rev_tag    <= dev_io.fwd_tag;
      dev_io.rev_data   <= wr_v ? '0 : mem_r[word_idx];
    end
  end

endmodule

`default_nettype wire

// File: bp_me_clint_slice.sv
/*
 * Core-local interruptor
 * mtime, mtimecmp and msip with timer and software interrupt outputs
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_clint_slice
  (input wire         clk_i
   , input wire       reset_i

   , bp_me_dev_if.dev dev_io

   , output logic     timer_irq_o
   , output logic     software_irq_o
   );

  import bp_me_msg_pkg::*;
  import bp_me_addr_pkg::*;

  localparam logic [19:0] msip_offset_lp     = 20'h0000;
  localparam logic [19:0] mtimecmp_offset_lp = 20'h4000;
  localparam logic [19:0] mtime_offset_lp    = 20'hBFF8;

  bp_addr_u                 addr_u;
  logic                     fwd_yumi;
  logic                     wr_v;
  logic [data_width_gp-1:0] rd_data;

  logic [data_width_gp-1:0] mtime_r;
  logic [data_width_gp-1:0] mtimecmp_r;
  logic                     msip_r;

  assign addr_u   = dev_io.fwd_addr;
  assign dev_io.fwd_ready_and = ~dev_io.rev_v | dev_io.rev_ready_and;
  assign fwd_yumi = dev_io.fwd_v & dev_io.fwd_ready_and;
  assign wr_v     = fwd_yumi & (dev_io.fwd_opcode == e_wr);

  always_comb begin
    rd_data = '0;
    case (addr_u.loc.offset)
      msip_offset_lp:     rd_data[0] = msip_r;
      mtimecmp_offset_lp: rd_data    = mtimecmp_r;
      mtime_offset_lp:    rd_data    = mtime_r;
      default:            rd_data    = '0;
    endcase
  end

  // mtime ticks on clk_i, a write to it takes priority
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end else begin
      mtime_r <= mtime_r + 1'b1;
      if (wr_v) begin
        case (addr_u.loc.offset)
          msip_offset_lp:     msip_r     <= dev_io.fwd_data[0];
          mtimecmp_offset_lp: mtimecmp_r <= dev_io.fwd_data;
          mtime_offset_lp:    mtime_r    <= dev_io.fwd_data;
          default:            ;
        endcase
      end
    end
  end

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dev_io.rev_v <= 1'b0;
    end else if (fwd_yumi) begin
      dev_io.rev_v <= 1'b1;
    end else if (dev_io.rev_ready_and) begin
      dev_io.rev_v <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_yumi) begin
      dev_io.rev_opcode <= dev_io.fwd_opcode;
      dev_io.rev_addr   <= dev_io.fwd_addr;
      dev_io.rev_tag    <= dev_io.fwd_tag;
      dev_io.rev_data   <= (dev_io.fwd_opcode == e_rd) ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

// File: bp_me_cfg_slice.sv
/*
 * Configuration slice
 * Freeze and core id registers plus read-only device ids
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_cfg_slice
  (input wire           clk_i
   , input wire         reset_i

   , bp_me_dev_if.dev   dev_io

   , input wire [7:0]   did_i
   , input wire [7:0]   host_did_i
   , output logic       freeze_o
   , output logic [7:0] core_id_o
   );

  import bp_me_msg_pkg::*;
  import bp_me_addr_pkg::*;

  localparam logic [19:0] freeze_offset_lp   = 20'h00;
  localparam logic [19:0] core_id_offset_lp  = 20'h08;
  localparam logic [19:0] did_offset_lp      = 20'h10;
  localparam logic [19:0] host_did_offset_lp = 20'h18;

  bp_addr_u                 addr_u;
  logic                     fwd_yumi;
  logic                     wr_v;
  logic [data_width_gp-1:0] rd_data;

  assign addr_u   = dev_io.fwd_addr;
  assign dev_io.fwd_ready_and = ~dev_io.rev_v | dev_io.rev_ready_and;
  assign fwd_yumi = dev_io.fwd_v & dev_io.fwd_ready_and;
  assign wr_v     = fwd_yumi & (dev_io.fwd_opcode == e_wr);

  always_comb begin
    rd_data = '0;
    case (addr_u.loc.offset)
      freeze_offset_lp:   rd_data[0]   = freeze_o;
      core_id_offset_lp:  rd_data[7:0] = core_id_o;
      did_offset_lp:      rd_data[7:0] = did_i;
      host_did_offset_lp: rd_data[7:0] = host_did_i;
      default:            rd_data      = '0;
    endcase
  end

  // Core comes out of reset frozen
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      freeze_o  <= 1'b1;
      core_id_o <= '0;
    end else if (wr_v) begin
      if (addr_u.loc.offset == freeze_offset_lp) begin
        freeze_o <= dev_io.fwd_data[0];
      end
      if (addr_u.loc.offset == core_id_offset_lp) begin
        core_id_o <= dev_io.fwd_data[7:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dev_io.rev_v <= 1'b0;
    end else if (fwd_yumi) begin
      dev_io.rev_v <= 1'b1;
    end else if (dev_io.rev_ready_and) begin
      dev_io.rev_v <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_yumi) begin
      dev_io.rev_opcode <= dev_io.fwd_opcode;
      dev_io.rev_addr   <= dev_io.fwd_addr;
      dev_io.rev_tag    <= dev_io.fwd_tag;
      dev_io.rev_data   <= (dev_io.fwd_opcode == e_rd) ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

// File: bp_me_rev_arb.sv
/*
 * Reverse arbiter
 * Round-robin merge of the four slice response streams
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_rev_arb
  (input wire                                           clk_i
   , input wire                                         reset_i

   , bp_me_dev_if.router                                dev_i [4]

   , output bp_me_msg_pkg::bp_me_opcode_e               mem_rev_opcode_o
   , output logic [bp_me_msg_pkg::paddr_width_gp-1:0]   mem_rev_addr_o
   , output logic [bp_me_msg_pkg::tag_width_gp-1:0]     mem_rev_tag_o
   , output logic [bp_me_msg_pkg::data_width_gp-1:0]    mem_rev_data_o
   , output logic                                       mem_rev_v_o
   , input wire                                         mem_rev_ready_and_i
   );

  import bp_me_msg_pkg::*;
  import bp_me_addr_pkg::*;

  bp_me_opcode_e             opcode_li [4];
  logic [paddr_width_gp-1:0] addr_li   [4];
  logic [tag_width_gp-1:0]   tag_li    [4];
  logic [data_width_gp-1:0]  data_li   [4];
  logic [3:0]                v_li;

  bp_dev_e ptr_r;
  bp_dev_e grant;
  logic    grant_v;

  for (genvar i = 0; i < 4; i++) begin : g_dev
    assign opcode_li[i] = dev_i[i].rev_opcode;
    assign addr_li[i]   = dev_i[i].rev_addr;
    assign tag_li[i]    = dev_i[i].rev_tag;
    assign data_li[i]   = dev_i[i].rev_data;
    assign v_li[i]      = dev_i[i].rev_v;

    assign dev_i[i].rev_ready_and = mem_rev_ready_and_i & grant_v
                                    & (grant == bp_dev_e'(i));
  end

  // Search downwards so the nearest valid at or after ptr wins
  always_comb begin
    bp_dev_e idx;
    grant   = ptr_r;
    grant_v = 1'b0;
    for (int k = 3; k >= 0; k--) begin
      idx = bp_dev_e'(ptr_r + 2'(k));
      if (v_li[idx]) begin
        grant   = idx;
        grant_v = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r <= e_dev_mem;
    end else if (grant_v & mem_rev_ready_and_i) begin
      ptr_r <= bp_dev_e'(grant + 2'd1);
    end
  end

  assign mem_rev_opcode_o = opcode_li[grant];
  assign mem_rev_addr_o   = addr_li[grant];
  assign mem_rev_tag_o    = tag_li[grant];
  assign mem_rev_data_o   = data_li[grant];
  assign mem_rev_v_o      = grant_v;

endmodule

`default_nettype wire

// File: bp_me_fwd_router.sv
/*
 * Forward router
 * Decodes each command address and steers it to one device slice
 */

`timescale 1ns/1ns
`default_nettype none

module bp_me_fwd_router
  (input wire bp_me_msg_pkg::bp_me_opcode_e          mem_fwd_opcode_i
   , input wire [bp_me_msg_pkg::paddr_width_gp-1:0]  mem_fwd_addr_i
   , input wire [bp_me_msg_pkg::tag_width_gp-1:0]    mem_fwd_tag_i
   , input wire [bp_me_msg_pkg::data_width_gp-1:0]   mem_fwd_data_i
   , input wire                                      mem_fwd_v_i
   , output logic                                    mem_fwd_ready_and_o

   , bp_me_dev_if.router                             dev_o [4]
   );

  import bp_me_addr_pkg::*;

  bp_addr_u   addr_u;
  bp_dev_e    dst;
  logic [3:0] dev_ready_li;

  assign addr_u = mem_fwd_addr_i;

  // Local space is split by dev id, the rest is DRAM
  always_comb begin
    dst = e_dev_mem;
    if (addr_u.raw < dram_base_addr_gp) begin
      case (addr_u.loc.dev)
        cfg_dev_gp:   dst = e_dev_cfg;
        clint_dev_gp: dst = e_dev_clint;
        cache_dev_gp: dst = e_dev_mem;
        default:      dst = e_dev_loop;
      endcase
    end
  end

  for (genvar i = 0; i < 4; i++) begin : g_dev
    assign dev_o[i].fwd_opcode = mem_fwd_opcode_i;
    assign dev_o[i].fwd_addr   = mem_fwd_addr_i;
    assign dev_o[i].fwd_tag    = mem_fwd_tag_i;
    assign dev_o[i].fwd_data   = mem_fwd_data_i;
    assign dev_o[i].fwd_v      = mem_fwd_v_i & (dst == bp_dev_e'(i));
    assign dev_ready_li[i]     = dev_o[i].fwd_ready_and;
  end

  assign mem_fwd_ready_and_o = dev_ready_li[dst];

endmodule

`default_nettype wire

// File: bp_me_dev_if.sv
/*
 * Device stream bundle
 * One slice's forward command stream and reverse response stream
 */

`timescale 1ns/1ns
`default_nettype none

interface bp_me_dev_if;
  import bp_me_msg_pkg::*;

  bp_me_opcode_e             fwd_opcode;
  logic [paddr_width_gp-1:0] fwd_addr;
  logic [tag_width_gp-1:0]   fwd_tag;
  logic [data_width_gp-1:0]  fwd_data;
  logic                      fwd_v;
  logic                      fwd_ready_and;

  bp_me_opcode_e             rev_opcode;
  logic [paddr_width_gp-1:0] rev_addr;
  logic [tag_width_gp-1:0]   rev_tag;
  logic [data_width_gp-1:0]  rev_data;
  logic                      rev_v;
  logic                      rev_ready_and;

  // Network side, shared by the router and the reverse arbiter
  modport router (
    output fwd_opcode, fwd_addr, fwd_tag, fwd_data, fwd_v,
    input  fwd_ready_and,
    input  rev_opcode, rev_addr, rev_tag, rev_data, rev_v,
    output rev_ready_and
  );

  modport dev (
    input  fwd_opcode, fwd_addr, fwd_tag, fwd_data, fwd_v,
    output fwd_ready_and,
    output rev_opcode, rev_addr, rev_tag, rev_data, rev_v,
    input  rev_ready_and
  );

endinterface

`default_nettype wire

// File: bp_me_addr_pkg.sv
/*
 * Device address map
 * DRAM base, local device ids and the two views of an address word
 */

`default_nettype none

package bp_me_addr_pkg;

  // Anything below this is a local device address
  localparam logic [bp_me_msg_pkg::paddr_width_gp-1:0] dram_base_addr_gp = 32'h8000_0000;

  localparam int dev_id_width_gp = 4;

  localparam logic [dev_id_width_gp-1:0] cfg_dev_gp   = 4'd1;
  localparam logic [dev_id_width_gp-1:0] clint_dev_gp = 4'd2;
  localparam logic [dev_id_width_gp-1:0] cache_dev_gp = 4'd3;

  // Raw global address, or local dev/offset pair
  typedef union packed {
    logic [bp_me_msg_pkg::paddr_width_gp-1:0] raw;
    struct packed {
      logic [7:0]                 pad;
      logic [dev_id_width_gp-1:0] dev;
      logic [19:0]                offset;
    } loc;
  } bp_addr_u;

  // Slice index on the router and arbiter side
  typedef enum logic [1:0] {
    e_dev_mem   = 2'd0,
    e_dev_cfg   = 2'd1,
    e_dev_clint = 2'd2,
    e_dev_loop  = 2'd3
  } bp_dev_e;

endpackage

`default_nettype wire

// File: bp_me_msg_pkg.sv
/*
 * Memory message definitions
 * Opcodes and field widths shared by the forward and reverse streams
 */

`default_nettype none

package bp_me_msg_pkg;

  // Physical address carried in every message header
  localparam int paddr_width_gp = 32;

  // One data beat per message
  localparam int data_width_gp = 64;

  // Tag is returned unchanged with the response
  localparam int tag_width_gp = 8;

  typedef enum logic [0:0] {
    e_rd = 1'b0,
    e_wr = 1'b1
  } bp_me_opcode_e;

endpackage

`default_nettype wire
